/* source/core_settings.svh */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// datapath and storage sizes
`define CORE_XLEN       32
`define CORE_REG_COUNT  32
`define CORE_REG_BITS   5
`define CORE_PC_BITS    8
`define CORE_IMEM_DEPTH 256
`define CORE_DMEM_DEPTH 256

// instruction fields
`define CORE_OP_MSB     31
`define CORE_OP_LSB     26
`define CORE_RS_MSB     25
`define CORE_RS_LSB     21
`define CORE_RT_MSB     20
`define CORE_RT_LSB     16
`define CORE_RD_MSB     15
`define CORE_RD_LSB     11
`define CORE_IMM_MSB    15
`define CORE_IMM_LSB    0

`endif

/* source/core_pkg.sv */
`default_nettype none

`include "core_settings.svh"

package core_pkg;

  typedef logic [`CORE_XLEN-1:0]                  word_t;
  typedef logic [`CORE_XLEN-1:0]                  instr_t;
  typedef logic [`CORE_REG_BITS-1:0]              reg_addr_t;
  typedef logic [`CORE_PC_BITS-1:0]               pc_t;
  typedef logic [`CORE_IMM_MSB-`CORE_IMM_LSB:0]   imm_t;

  typedef enum logic [`CORE_OP_MSB-`CORE_OP_LSB:0] {
    op_nop  = 6'd0,
    op_add  = 6'd1,
    op_sub  = 6'd2,
    op_and  = 6'd3,
    op_or   = 6'd4,
    op_slt  = 6'd5,
    op_addi = 6'd6,
    op_lw   = 6'd7,
    op_sw   = 6'd8,
    op_beq  = 6'd9,
    op_j    = 6'd10
  } opcode_e;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_slt
  } alu_op_e;

  typedef struct packed {
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    alu_src;
    logic    branch;
    logic    jump;
    alu_op_e alu_op;
  } ctrl_t;

  typedef struct packed {
    logic   valid;
    pc_t    pc;
    instr_t instr;
  } fetch_t;

  typedef struct packed {
    logic      valid;
    ctrl_t     ctrl;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t dst;
    word_t     a;
    word_t     b;
    imm_t      imm;
  } id_ex_t;

  typedef struct packed {
    logic      valid;
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;
    reg_addr_t dst;
    word_t     result;
    word_t     store_data;
  } ex_mem_t;

  // register result and core output
  typedef struct packed {
    logic      valid;
    reg_addr_t dst;
    word_t     data;
  } wb_t;

  typedef struct packed {
    logic taken;
    pc_t  target;
  } redirect_t;

endpackage

`default_nettype wire

/* source/fetch_unit.sv */
`default_nettype none

`include "core_settings.svh"

module fetch_unit (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                run,
  input  logic                imem_we,
  input  core_pkg::pc_t       imem_addr,
  input  core_pkg::instr_t    imem_data,
  input  logic                stall,
  input  core_pkg::redirect_t redirect,
  output core_pkg::fetch_t    fetch
);

  core_pkg::pc_t    pc;
  core_pkg::instr_t imem [`CORE_IMEM_DEPTH];

  // program load port
  always_ff @(posedge clk) begin
    if (imem_we) begin
      imem[imem_addr] <= imem_data;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= '0;
    end else if (redirect.taken) begin
      pc <= redirect.target;
    end else if (run && !stall) begin
      pc <= pc + core_pkg::pc_t'(1);
    end
  end

  // redirect flush wins over a stall hold
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      fetch <= '0;
    end else if (redirect.taken) begin
      fetch <= '0;
    end else if (!stall) begin
      if (run) begin
        fetch.valid <= 1'b1;
        fetch.pc    <= pc;
        fetch.instr <= imem[pc];
      end else begin
        fetch <= '0;
      end
    end
  end

endmodule

`default_nettype wire

/* source/register_file.sv */
`default_nettype none

`include "core_settings.svh"

module register_file (
  input  logic                clk,
  input  logic                arst_n,
  input  core_pkg::reg_addr_t rs,
  input  core_pkg::reg_addr_t rt,
  output core_pkg::word_t     a,
  output core_pkg::word_t     b,
  input  core_pkg::wb_t       wb
);

  core_pkg::word_t regs [`CORE_REG_COUNT];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `CORE_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.valid) begin
      regs[wb.dst] <= wb.data;
    end
  end

  // write-through on a same-cycle write
  assign a = (wb.valid && wb.dst == rs) ? wb.data : regs[rs];
  assign b = (wb.valid && wb.dst == rt) ? wb.data : regs[rt];

endmodule

`default_nettype wire

/* source/decode_stage.sv */
`default_nettype none

`include "core_settings.svh"

module decode_stage (
  input  logic                clk,
  input  logic                arst_n,
  input  core_pkg::fetch_t    fetch,
  input  core_pkg::redirect_t redirect,
  input  core_pkg::wb_t       wb,
  output logic                stall,
  output core_pkg::id_ex_t    id_ex
);

  core_pkg::opcode_e   opcode;
  core_pkg::reg_addr_t rs;
  core_pkg::reg_addr_t rt;
  core_pkg::reg_addr_t rd;
  core_pkg::reg_addr_t dst;
  core_pkg::imm_t      imm;
  core_pkg::ctrl_t     ctrl;
  core_pkg::word_t     a;
  core_pkg::word_t     b;

  //////////////////////////////////////////////////
  // fields and control
  //////////////////////////////////////////////////

  assign opcode = core_pkg::opcode_e'(fetch.instr[`CORE_OP_MSB:`CORE_OP_LSB]);
  assign rs     = fetch.instr[`CORE_RS_MSB:`CORE_RS_LSB];
  assign rt     = fetch.instr[`CORE_RT_MSB:`CORE_RT_LSB];
  assign rd     = fetch.instr[`CORE_RD_MSB:`CORE_RD_LSB];
  assign imm    = fetch.instr[`CORE_IMM_MSB:`CORE_IMM_LSB];

  always_comb begin
    ctrl = '0;
    dst  = rd;
    case (opcode)
      core_pkg::op_add: ctrl.reg_write = 1'b1;
      core_pkg::op_sub: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = core_pkg::alu_sub;
      end
      core_pkg::op_and: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = core_pkg::alu_and;
      end
      core_pkg::op_or: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = core_pkg::alu_or;
      end
      core_pkg::op_slt: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = core_pkg::alu_slt;
      end
      core_pkg::op_addi: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        dst            = rt;
      end
      core_pkg::op_lw: begin
        ctrl.reg_write = 1'b1;
        ctrl.mem_read  = 1'b1;
        ctrl.alu_src   = 1'b1;
        dst            = rt;
      end
      core_pkg::op_sw: begin
        ctrl.mem_write = 1'b1;
        ctrl.alu_src   = 1'b1;
      end
      core_pkg::op_beq: ctrl.branch = 1'b1;
      core_pkg::op_j:   ctrl.jump   = 1'b1;
      default:          ctrl = '0;
    endcase
    // r0 is never written
    if (dst == '0) begin
      ctrl.reg_write = 1'b0;
    end
  end

  register_file u_register_file (
    .clk    (clk),
    .arst_n (arst_n),
    .rs     (rs),
    .rt     (rt),
    .a      (a),
    .b      (b),
    .wb     (wb)
  );

  // load-use hazard against the load now in execute
  assign stall = fetch.valid && id_ex.valid && id_ex.ctrl.mem_read &&
                 (id_ex.dst == rs || id_ex.dst == rt);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      id_ex <= '0;
    end else if (redirect.taken || stall) begin
      id_ex <= '0;
    end else begin
      id_ex.valid <= fetch.valid;
      id_ex.ctrl  <= ctrl;
      id_ex.rs    <= rs;
      id_ex.rt    <= rt;
      id_ex.dst   <= dst;
      id_ex.a     <= a;
      id_ex.b     <= b;
      id_ex.imm   <= imm;
    end
  end

endmodule

`default_nettype wire

/* source/execute_stage.sv */
`default_nettype none

`include "core_settings.svh"

module execute_stage (
  input  logic                clk,
  input  logic                arst_n,
  input  core_pkg::id_ex_t    id_ex,
  input  core_pkg::wb_t       wb,
  output core_pkg::redirect_t redirect,
  output core_pkg::ex_mem_t   ex_mem
);

  core_pkg::word_t op_a;
  core_pkg::word_t op_b;
  core_pkg::word_t alu_b;
  core_pkg::word_t result;

  // newest producer first
  // loads in ex_mem are not ready yet
  function automatic core_pkg::word_t forward(
    input core_pkg::reg_addr_t src,
    input core_pkg::word_t     reg_val,
    input core_pkg::ex_mem_t   em,
    input core_pkg::wb_t       w
  );
    core_pkg::word_t val;
    val = reg_val;
    if (em.valid && em.reg_write && !em.mem_read && em.dst == src) begin
      val = em.result;
    end else if (w.valid && w.dst == src) begin
      val = w.data;
    end
    return val;
  endfunction

  assign op_a  = forward(id_ex.rs, id_ex.a, ex_mem, wb);
  assign op_b  = forward(id_ex.rt, id_ex.b, ex_mem, wb);
  assign alu_b = id_ex.ctrl.alu_src ? core_pkg::word_t'(id_ex.imm) : op_b;

  //////////////////////////////////////////////////
  // alu
  //////////////////////////////////////////////////

  always_comb begin
    case (id_ex.ctrl.alu_op)
      core_pkg::alu_add: result = op_a + alu_b;
      core_pkg::alu_sub: result = op_a - alu_b;
      core_pkg::alu_and: result = op_a & alu_b;
      core_pkg::alu_or:  result = op_a | alu_b;
      core_pkg::alu_slt: result = core_pkg::word_t'($signed(op_a) < $signed(alu_b));
      default:           result = '0;
    endcase
  end

  // absolute word target from the immediate
  assign redirect.taken  = id_ex.valid &&
                           (id_ex.ctrl.jump || (id_ex.ctrl.branch && op_a == op_b));
  assign redirect.target = id_ex.imm[`CORE_PC_BITS-1:0];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_mem <= '0;
    end else begin
      ex_mem.valid      <= id_ex.valid;
      ex_mem.reg_write  <= id_ex.ctrl.reg_write;
      ex_mem.mem_read   <= id_ex.ctrl.mem_read;
      ex_mem.mem_write  <= id_ex.ctrl.mem_write;
      ex_mem.dst        <= id_ex.dst;
      ex_mem.result     <= result;
      ex_mem.store_data <= op_b;
    end
  end

endmodule

`default_nettype wire

/* source/memory_stage.sv */
`default_nettype none

`include "core_settings.svh"

module memory_stage (
  input  logic              clk,
  input  logic              arst_n,
  input  core_pkg::ex_mem_t ex_mem,
  output core_pkg::wb_t     wb
);

  core_pkg::word_t dmem [`CORE_DMEM_DEPTH];
  core_pkg::pc_t   addr;
  core_pkg::word_t load_data;

  assign addr      = ex_mem.result[`CORE_PC_BITS-1:0];
  assign load_data = dmem[addr];

  always_ff @(posedge clk) begin
    if (ex_mem.valid && ex_mem.mem_write) begin
      dmem[addr] <= ex_mem.store_data;
    end
  end

  // strobe only for register writers
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb <= '0;
    end else begin
      wb.valid <= ex_mem.valid && ex_mem.reg_write;
      wb.dst   <= ex_mem.dst;
      wb.data  <= ex_mem.mem_read ? load_data : ex_mem.result;
    end
  end

endmodule

`default_nettype wire

/* source/pipeline_core.sv */
`default_nettype none

module pipeline_core (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             imem_we,
  input  core_pkg::pc_t    imem_addr,
  input  core_pkg::instr_t imem_data,
  input  logic             run,
  output core_pkg::wb_t    wb
);

  core_pkg::fetch_t    fetch;
  core_pkg::id_ex_t    id_ex;
  core_pkg::ex_mem_t   ex_mem;
  core_pkg::redirect_t redirect;
  logic                stall;

  //////////////////////////////////////////////////
  // stages
  //////////////////////////////////////////////////

  fetch_unit u_fetch_unit (
    .clk       (clk),
    .arst_n    (arst_n),
    .run       (run),
    .imem_we   (imem_we),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .stall     (stall),
    .redirect  (redirect),
    .fetch     (fetch)
  );

  decode_stage u_decode_stage (
    .clk      (clk),
    .arst_n   (arst_n),
    .fetch    (fetch),
    .redirect (redirect),
    .wb       (wb),
    .stall    (stall),
    .id_ex    (id_ex)
  );

  execute_stage u_execute_stage (
    .clk      (clk),
    .arst_n   (arst_n),
    .id_ex    (id_ex),
    .wb       (wb),
    .redirect (redirect),
    .ex_mem   (ex_mem)
  );

  // wb feeds the register file, forwarding and the output
  memory_stage u_memory_stage (
    .clk    (clk),
    .arst_n (arst_n),
    .ex_mem (ex_mem),
    .wb     (wb)
  );

endmodule

`default_nettype wire

/* test/core_checker.sv */
`default_nettype none

`include "core_settings.svh"

module core_checker (
  input  logic             clk,
  input  logic             imem_we,
  input  core_pkg::pc_t    imem_addr,
  input  core_pkg::instr_t imem_data,
  input  logic             run,
  input  core_pkg::wb_t    wb,
  output logic             done,
  output int               errors,
  output int               writes_checked,
  output int               tests_run,
  output int               tests_failed
);

  localparam int max_steps = 4096;

  core_pkg::instr_t    image    [`CORE_IMEM_DEPTH];
  core_pkg::reg_addr_t exp_dst  [max_steps];
  core_pkg::word_t     exp_data [max_steps];
  int                  exp_count   = 0;
  int                  idx         = 0;
  int                  test_errors = 0;
  logic                active      = 1'b0;
  logic                run_q       = 1'b0;
  logic                bad;

  initial begin
    done           = 1'b0;
    errors         = 0;
    writes_checked = 0;
    tests_run      = 0;
    tests_failed   = 0;
  end

  //////////////////////////////////////////////////
  // ISA reference model
  //////////////////////////////////////////////////

  // runs the image from pc 0
  // write count, or -1 when no self-jump is reached
  function automatic int build_expected();
    core_pkg::word_t     regs [`CORE_REG_COUNT];
    core_pkg::word_t     dmem [`CORE_DMEM_DEPTH];
    core_pkg::instr_t    ins;
    core_pkg::opcode_e   op;
    core_pkg::pc_t       pc;
    core_pkg::pc_t       target;
    core_pkg::pc_t       addr;
    core_pkg::reg_addr_t rs;
    core_pkg::reg_addr_t rt;
    core_pkg::reg_addr_t dst;
    core_pkg::word_t     imm;
    core_pkg::word_t     sum;
    core_pkg::word_t     val;
    logic                wr;
    int                  n;
    for (int i = 0; i < `CORE_REG_COUNT; i++) begin
      regs[i] = '0;
    end
    for (int i = 0; i < `CORE_DMEM_DEPTH; i++) begin
      dmem[i] = '0;
    end
    pc = '0;
    n  = 0;
    for (int step = 0; step < max_steps; step++) begin
      ins    = image[pc];
      op     = core_pkg::opcode_e'(ins[`CORE_OP_MSB:`CORE_OP_LSB]);
      rs     = ins[`CORE_RS_MSB:`CORE_RS_LSB];
      rt     = ins[`CORE_RT_MSB:`CORE_RT_LSB];
      dst    = ins[`CORE_RD_MSB:`CORE_RD_LSB];
      imm    = {16'd0, ins[`CORE_IMM_MSB:`CORE_IMM_LSB]};
      target = ins[`CORE_PC_BITS-1:0];
      sum    = regs[rs] + imm;
      addr   = sum[`CORE_PC_BITS-1:0];
      wr     = 1'b1;
      val    = '0;
      case (op)
        core_pkg::op_add: val = regs[rs] + regs[rt];
        core_pkg::op_sub: val = regs[rs] - regs[rt];
        core_pkg::op_and: val = regs[rs] & regs[rt];
        core_pkg::op_or:  val = regs[rs] | regs[rt];
        core_pkg::op_slt: val = ($signed(regs[rs]) < $signed(regs[rt])) ? 32'd1 : 32'd0;
        core_pkg::op_addi: begin
          val = sum;
          dst = rt;
        end
        core_pkg::op_lw: begin
          val = dmem[addr];
          dst = rt;
        end
        core_pkg::op_sw: begin
          dmem[addr] = regs[rt];
          wr         = 1'b0;
        end
        default: wr = 1'b0;
      endcase
      if (wr && dst != '0) begin
        regs[dst]   = val;
        exp_dst[n]  = dst;
        exp_data[n] = val;
        n++;
      end
      if (op == core_pkg::op_j && target == pc) begin
        return n;
      end else if (op == core_pkg::op_j || (op == core_pkg::op_beq && regs[rs] == regs[rt])) begin
        pc = target;
      end else begin
        pc = pc + core_pkg::pc_t'(1);
      end
    end
    return -1;
  endfunction

  //////////////////////////////////////////////////
  // writeback compare
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    if (imem_we) begin
      image[imem_addr] = imem_data;
    end
    if (run && !run_q) begin
      exp_count   = build_expected();
      idx         = 0;
      test_errors = 0;
      active      = 1'b1;
      if (exp_count < 0) begin
        $display("test %0d: reference model never reached the self-jump", tests_run + 1);
        exp_count   = 0;
        test_errors = 1;
        errors++;
      end
    end
    if (wb.valid) begin
      if (!active || idx >= exp_count) begin
        $display("register write to r%0d arrived when no write was expected", wb.dst);
        test_errors++;
        errors++;
      end else begin
        bad = 1'b0;
        if (wb.dst !== exp_dst[idx]) begin
          $display("Mismatch wb.dst: expected 0x%h, got 0x%h", exp_dst[idx], wb.dst);
          bad = 1'b1;
        end
        if (wb.data !== exp_data[idx]) begin
          $display("Mismatch wb.data: expected 0x%h, got 0x%h", exp_data[idx], wb.data);
          bad = 1'b1;
        end
        if (bad) begin
          test_errors++;
          errors++;
        end
        idx++;
        writes_checked++;
      end
    end
    if (!run && run_q) begin
      $display("test %0d: %0d of %0d writes checked, %0d errors, %s", tests_run + 1, idx,
               exp_count, test_errors, (test_errors == 0 && idx == exp_count) ? "ok" : "failed");
      tests_run++;
      if (test_errors != 0 || idx != exp_count) begin
        tests_failed++;
      end
      active = 1'b0;
    end
    run_q = run;
    done <= active && idx == exp_count;
  end

endmodule

`default_nettype wire

/* test/core_tb.sv */
`default_nettype none

`include "core_settings.svh"

module core_tb;

  logic             clk = 1'b0;
  logic             arst_n;
  logic             imem_we;
  core_pkg::pc_t    imem_addr;
  core_pkg::instr_t imem_data;
  logic             run;
  core_pkg::wb_t    wb;
  logic             done;
  int               errors;
  int               writes_checked;
  int               tests_run;
  int               tests_failed;

  core_pkg::instr_t prog [`CORE_IMEM_DEPTH];
  int               prog_len    = 0;
  int               cycle_limit = 0;
  int               run_cycles  = 0;
  integer           seed        = 32'h4eac;

  always #20 clk = ~clk;

  pipeline_core u_dut (
    .clk       (clk),
    .arst_n    (arst_n),
    .imem_we   (imem_we),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .run       (run),
    .wb        (wb)
  );

  core_checker u_checker (
    .clk            (clk),
    .imem_we        (imem_we),
    .imem_addr      (imem_addr),
    .imem_data      (imem_data),
    .run            (run),
    .wb             (wb),
    .done           (done),
    .errors         (errors),
    .writes_checked (writes_checked),
    .tests_run      (tests_run),
    .tests_failed   (tests_failed)
  );

  // limit grows by each test's budget as it starts
  always @(posedge clk) begin
    if (run) begin
      run_cycles++;
      if (run_cycles > cycle_limit) begin
        $display("test %0d ran out of its cycle budget, %0d cycles used in all",
                 tests_run + 1, run_cycles);
        $display("*** FAILED ***");
        $finish;
      end
    end
  end

  //////////////////////////////////////////////////
  // program building
  //////////////////////////////////////////////////

  function automatic core_pkg::instr_t r_instr(core_pkg::opcode_e op, core_pkg::reg_addr_t rd,
                                               core_pkg::reg_addr_t rs, core_pkg::reg_addr_t rt);
    return {op, rs, rt, rd, 11'd0};
  endfunction

  function automatic core_pkg::instr_t i_instr(core_pkg::opcode_e op, core_pkg::reg_addr_t rt,
                                               core_pkg::reg_addr_t rs, core_pkg::imm_t imm);
    return {op, rs, rt, imm};
  endfunction

  task automatic add_instr(core_pkg::instr_t ins);
    prog[prog_len] = ins;
    prog_len++;
  endtask

  task automatic self_jump();
    add_instr(i_instr(core_pkg::op_j, 0, 0, core_pkg::imm_t'(prog_len)));
  endtask

  task automatic alu_program();
    add_instr(i_instr(core_pkg::op_addi, 1, 0, 16'h0005));
    add_instr(i_instr(core_pkg::op_addi, 2, 0, 16'h0009));
    add_instr(i_instr(core_pkg::op_addi, 3, 0, 16'hfff0));
    repeat (3) add_instr('0);
    add_instr(r_instr(core_pkg::op_add, 4, 1, 2));
    add_instr(r_instr(core_pkg::op_sub, 5, 1, 2));
    add_instr(r_instr(core_pkg::op_and, 6, 2, 3));
    add_instr(r_instr(core_pkg::op_or, 7, 1, 3));
    add_instr(r_instr(core_pkg::op_slt, 8, 5, 1));
    add_instr(r_instr(core_pkg::op_slt, 9, 1, 5));
    // r0 targets give no strobe
    add_instr(r_instr(core_pkg::op_add, 0, 1, 2));
    add_instr(i_instr(core_pkg::op_addi, 0, 3, 16'h0042));
    self_jump();
  endtask

  task automatic forwarding_program();
    add_instr(i_instr(core_pkg::op_addi, 1, 0, 16'h0003));
    add_instr(r_instr(core_pkg::op_add, 2, 1, 1));
    add_instr(r_instr(core_pkg::op_add, 3, 2, 1));
    add_instr(r_instr(core_pkg::op_sub, 4, 3, 1));
    add_instr(r_instr(core_pkg::op_or, 5, 2, 4));
    add_instr(i_instr(core_pkg::op_addi, 6, 5, 16'h0100));
    add_instr(r_instr(core_pkg::op_slt, 7, 6, 5));
    add_instr(r_instr(core_pkg::op_and, 8, 7, 6));
    add_instr(i_instr(core_pkg::op_addi, 1, 1, 16'h0001));
    add_instr(r_instr(core_pkg::op_add, 9, 1, 1));
    self_jump();
  endtask

  task automatic load_store_program();
    add_instr(i_instr(core_pkg::op_addi, 1, 0, 16'h0055));
    add_instr(i_instr(core_pkg::op_addi, 2, 0, 16'h00aa));
    add_instr(i_instr(core_pkg::op_sw, 1, 0, 16'h0004));
    add_instr(i_instr(core_pkg::op_sw, 2, 0, 16'h0008));
    add_instr(i_instr(core_pkg::op_lw, 3, 0, 16'h0004));
    add_instr(i_instr(core_pkg::op_lw, 4, 0, 16'h0008));
    add_instr(r_instr(core_pkg::op_add, 5, 4, 3));
    add_instr(i_instr(core_pkg::op_lw, 6, 0, 16'h0004));
    add_instr(i_instr(core_pkg::op_sw, 6, 0, 16'h000c));
    add_instr(i_instr(core_pkg::op_lw, 7, 0, 16'h000c));
    add_instr(i_instr(core_pkg::op_addi, 8, 7, 16'h0001));
    add_instr(i_instr(core_pkg::op_addi, 9, 0, 16'h0010));
    add_instr(i_instr(core_pkg::op_sw, 5, 9, 16'h0000));
    add_instr(i_instr(core_pkg::op_lw, 10, 9, 16'h0000));
    self_jump();
  endtask

  task automatic branch_program();
    add_instr(i_instr(core_pkg::op_addi, 1, 0, 16'h0007));
    add_instr(i_instr(core_pkg::op_addi, 2, 0, 16'h0007));
    add_instr(i_instr(core_pkg::op_beq, 2, 1, 16'd5));
    add_instr(i_instr(core_pkg::op_addi, 3, 0, 16'h0001));
    add_instr(i_instr(core_pkg::op_addi, 4, 0, 16'h0002));
    add_instr(i_instr(core_pkg::op_addi, 5, 0, 16'h0003));
    add_instr(i_instr(core_pkg::op_beq, 5, 1, 16'd9));
    add_instr(i_instr(core_pkg::op_addi, 6, 0, 16'h0004));
    add_instr(i_instr(core_pkg::op_j, 0, 0, 16'd10));
    add_instr(i_instr(core_pkg::op_addi, 7, 0, 16'h0005));
    add_instr(i_instr(core_pkg::op_addi, 8, 0, 16'h0006));
    self_jump();
  endtask

  // loads only read addresses that an earlier sw wrote
  task automatic random_program();
    logic [31:0]         rnd;
    int                  kind;
    core_pkg::reg_addr_t rd;
    core_pkg::reg_addr_t rs;
    core_pkg::reg_addr_t rt;
    core_pkg::imm_t      addr;
    core_pkg::pc_t       stored [$];
    for (int i = 0; i < 24; i++) begin
      rnd  = $random(seed);
      kind = rnd[2:0];
      rd   = {2'b00, rnd[5:3]};
      rs   = {2'b00, rnd[8:6]};
      rt   = {2'b00, rnd[11:9]};
      if (kind == 7 && stored.size() == 0) begin
        kind = 5;
      end
      case (kind)
        0: add_instr(r_instr(core_pkg::op_add, rd, rs, rt));
        1: add_instr(r_instr(core_pkg::op_sub, rd, rs, rt));
        2: add_instr(r_instr(core_pkg::op_and, rd, rs, rt));
        3: add_instr(r_instr(core_pkg::op_or, rd, rs, rt));
        4: add_instr(r_instr(core_pkg::op_slt, rd, rs, rt));
        5: add_instr(i_instr(core_pkg::op_addi, rt, rs, rnd[31:16]));
        6: begin
          stored.push_back({4'd0, rnd[15:12]});
          add_instr(i_instr(core_pkg::op_sw, rt, 0, {12'd0, rnd[15:12]}));
        end
        default: begin
          addr = {8'd0, stored[rnd[31:16] % stored.size()]};
          add_instr(i_instr(core_pkg::op_lw, rt, 0, addr));
        end
      endcase
    end
    self_jump();
  endtask

  //////////////////////////////////////////////////
  // test sequencing
  //////////////////////////////////////////////////

  task automatic run_program();
    cycle_limit += prog_len * 4 + 40;
    @(posedge clk);
    arst_n <= 1'b0;
    run    <= 1'b0;
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;
    for (int i = 0; i < prog_len; i++) begin
      @(posedge clk);
      imem_we   <= 1'b1;
      imem_addr <= core_pkg::pc_t'(i);
      imem_data <= prog[i];
    end
    @(posedge clk);
    imem_we <= 1'b0;
    // idle with run low and no strobe allowed
    repeat (10) @(posedge clk);
    run <= 1'b1;
    @(posedge clk);
    while (!done) begin
      @(posedge clk);
    end
    // keep running to catch extra writes
    repeat (8) @(posedge clk);
    run <= 1'b0;
    repeat (3) @(posedge clk);
    prog_len = 0;
  endtask

  initial begin
    arst_n    = 1'b0;
    run       = 1'b0;
    imem_we   = 1'b0;
    imem_addr = '0;
    imem_data = '0;
    alu_program();
    run_program();
    forwarding_program();
    run_program();
    load_store_program();
    run_program();
    branch_program();
    run_program();
    for (int t = 0; t < 20; t++) begin
      random_program();
      run_program();
    end
    $display("%0d tests run, %0d failed, %0d writes checked, %0d errors",
             tests_run, tests_failed, writes_checked, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+source
source/core_pkg.sv
source/fetch_unit.sv
source/register_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/pipeline_core.sv
test/core_checker.sv
test/core_tb.sv

/* Bender.yml */
package:
  name: pipeline_core

export_include_dirs:
  - source

sources:
  - source/core_pkg.sv
  - source/fetch_unit.sv
  - source/register_file.sv
  - source/decode_stage.sv
  - source/execute_stage.sv
  - source/memory_stage.sv
  - source/pipeline_core.sv
  - target: test
    files:
      - test/core_checker.sv
      - test/core_tb.sv
